// File: logic/dualPortRam.sv
`timescale 1ns/100ps

module dualPortRam import storePkg::*; (
  input  logic                  clk,
  // Write port
  input  logic                  storeEn,
  input  logic [ADDR_WIDTH-1:0] storeAddr,
  input  logic [DATA_WIDTH-1:0] storeData,
  // Read port
  input  logic                  rdEn,
  input  logic [ADDR_WIDTH-1:0] rdAddr,
  output logic [DATA_WIDTH-1:0] rdData
);

  localparam int WORDS = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [WORDS];

  always_ff @(posedge clk) begin
    if (storeEn) begin
      mem[storeAddr] <= storeData;
    end
  end

  // Registered read with data one cycle after rdEn
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

// File: logic/elasticFifo.sv
`timescale 1ns/100ps

module elasticFifo #(
  parameter type payload_t = logic,
  parameter int DEPTH = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t inData,
  input  logic     inValid,
  output logic     inReady,
  output payload_t outData,
  output logic     outValid,
  input  logic     outReady
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_WIDTH-1:0] wrPtr;
  logic [PTR_WIDTH-1:0] rdPtr;
  logic [CNT_WIDTH-1:0] count;
  logic [CNT_WIDTH-1:0] countNext;
  logic push;
  logic pop;

  function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = inValid && inReady;
  assign pop = outValid && outReady;
  assign outValid = (count != '0);
  assign outData = mem[rdPtr];

  always_comb begin
    case ({push, pop})
      2'b10:   countNext = count + 1'b1;
      2'b01:   countNext = count - 1'b1;
      default: countNext = count;
    endcase
  end

  // Ready is registered, so it stays low while reset is asserted
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inReady <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      count <= countNext;
      inReady <= (countNext != CNT_WIDTH'(DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

endmodule

// File: logic/memControllerLoadless.sv
`timescale 1ns/100ps

module memControllerLoadless import storePkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // Control tokens
  input  ctrlToken_t            ctrl,
  input  logic                  ctrlValid,
  output logic                  ctrlReady,
  // Merged store requests
  input  storeReq_t             storeReq,
  input  logic                  storeReqValid,
  output logic                  storeReqReady,
  // Done channel
  output logic                  memDoneValid,
  input  logic                  memDoneReady,
  // RAM write port
  output logic                  storeEn,
  output logic [ADDR_WIDTH-1:0] storeAddr,
  output logic [DATA_WIDTH-1:0] storeData
);

  // Two extra bits for sign and headroom when stores run ahead of the token
  logic signed [COUNT_WIDTH+1:0] pending;
  logic signed [COUNT_WIDTH+1:0] pendingNext;
  logic ctrlPop;
  logic storePop;
  logic armed;
  logic doneXfer;

  // Both inputs are drained as soon as anything shows up
  assign ctrlReady = 1'b1;
  assign storeReqReady = 1'b1;

  assign ctrlPop = ctrlValid && ctrlReady;
  assign storePop = storeReqValid && storeReqReady;

  always_comb begin
    pendingNext = pending;
    if (ctrlPop) begin
      pendingNext = pendingNext + $signed({2'b00, ctrl.storeCount});
    end
    if (storePop) begin
      pendingNext = pendingNext - 1;
    end
  end

  // Wait for the last write to leave the port before signalling done
  assign memDoneValid = armed && (pending == '0) && !ctrlValid && !storeEn;
  assign doneXfer = memDoneValid && memDoneReady;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= '0;
      armed <= 1'b0;
      storeEn <= 1'b0;
    end else begin
      pending <= pendingNext;
      storeEn <= storePop;
      // One done token per batch
      if (ctrlPop) begin
        armed <= 1'b1;
      end else if (doneXfer) begin
        armed <= 1'b0;
      end
    end
  end

  // Write port payload
  always_ff @(posedge clk) begin
    if (storePop) begin
      storeAddr <= storeReq.addr;
      storeData <= storeReq.data;
    end
  end

endmodule

// File: logic/storeArbiter.sv
`timescale 1ns/100ps

module storeArbiter import storePkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [NUM_STORE-1:0][ADDR_WIDTH-1:0] stAddr,
  input  logic [NUM_STORE-1:0][DATA_WIDTH-1:0] stData,
  input  logic [NUM_STORE-1:0]                  stAddrValid,
  input  logic [NUM_STORE-1:0]                  stDataValid,
  output logic [NUM_STORE-1:0]                  stAddrReady,
  output logic [NUM_STORE-1:0]                  stDataReady,
  output storeReq_t                             req,
  output logic                                  reqValid,
  input  logic                                  reqReady
);

  logic [NUM_STORE-1:0] joined;
  logic [PORT_WIDTH-1:0] lastGrant;
  logic [PORT_WIDTH-1:0] grantIdx;
  logic grantValid;
  logic running;
  logic accept;

  // A port only competes once both its address and data are present
  assign joined = stAddrValid & stDataValid;

  // Search starts one past the port served last
  always_comb begin : grantSearch
    int idx;
    grantValid = 1'b0;
    grantIdx = lastGrant;
    for (int k = 1; k <= NUM_STORE; k++) begin
      idx = (int'(lastGrant) + k) % NUM_STORE;
      if (!grantValid && joined[idx]) begin
        grantValid = 1'b1;
        grantIdx = PORT_WIDTH'(idx);
      end
    end
  end

  // Output slot is free when empty or draining this cycle
  assign accept = running && grantValid && (!reqValid || reqReady);

  always_comb begin
    for (int i = 0; i < NUM_STORE; i++) begin
      stAddrReady[i] = accept && (grantIdx == PORT_WIDTH'(i));
      stDataReady[i] = accept && (grantIdx == PORT_WIDTH'(i));
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      running <= 1'b0;
      reqValid <= 1'b0;
      lastGrant <= PORT_WIDTH'(NUM_STORE - 1);
    end else begin
      running <= 1'b1;
      if (accept) begin
        reqValid <= 1'b1;
        lastGrant <= grantIdx;
      end else if (reqReady) begin
        reqValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.addr <= stAddr[grantIdx];
      req.data <= stData[grantIdx];
    end
  end

endmodule

// File: logic/storePkg.sv
package storePkg;

  // RAM geometry
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // Store side of the kernel
  localparam int NUM_STORE = 2;
  localparam int PORT_WIDTH = (NUM_STORE > 1) ? $clog2(NUM_STORE) : 1;

  // Width of the announced store count
  localparam int COUNT_WIDTH = 16;

  // Buffer depths
  localparam int STORE_FIFO_DEPTH = 4;
  localparam int CTRL_FIFO_DEPTH = 2;

  // One merged store request after the arbiter
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } storeReq_t;

  // Number of stores announced by one control token
  typedef struct packed {
    logic [COUNT_WIDTH-1:0] storeCount;
  } ctrlToken_t;

endpackage

// File: logic/storeSubsystem.sv
`timescale 1ns/100ps

module storeSubsystem import storePkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  // Store ports
  input  logic [NUM_STORE-1:0][ADDR_WIDTH-1:0] stAddr,
  input  logic [NUM_STORE-1:0][DATA_WIDTH-1:0] stData,
  input  logic [NUM_STORE-1:0]                  stAddrValid,
  input  logic [NUM_STORE-1:0]                  stDataValid,
  output logic [NUM_STORE-1:0]                  stAddrReady,
  output logic [NUM_STORE-1:0]                  stDataReady,
  // Control tokens
  input  ctrlToken_t                            ctrl,
  input  logic                                  ctrlValid,
  output logic                                  ctrlReady,
  // Done channel
  output logic                                  memDoneValid,
  input  logic                                  memDoneReady,
  // RAM read port for the next stage
  input  logic                                  rdEn,
  input  logic [ADDR_WIDTH-1:0]                 rdAddr,
  output logic [DATA_WIDTH-1:0]                 rdData
);

  storeReq_t arbReq;
  logic arbReqValid;
  logic arbReqReady;

  storeReq_t bufReq;
  logic bufReqValid;
  logic bufReqReady;

  ctrlToken_t bufCtrl;
  logic bufCtrlValid;
  logic bufCtrlReady;

  logic storeEn;
  logic [ADDR_WIDTH-1:0] storeAddr;
  logic [DATA_WIDTH-1:0] storeData;

  storeArbiter arbiter0 (
    .clk         (clk),
    .rst         (rst),
    .stAddr      (stAddr),
    .stData      (stData),
    .stAddrValid (stAddrValid),
    .stDataValid (stDataValid),
    .stAddrReady (stAddrReady),
    .stDataReady (stDataReady),
    .req         (arbReq),
    .reqValid    (arbReqValid),
    .reqReady    (arbReqReady)
  );

  // Store request buffer
  elasticFifo #(
    .payload_t (storeReq_t),
    .DEPTH     (STORE_FIFO_DEPTH)
  ) storeFifo0 (
    .clk      (clk),
    .rst      (rst),
    .inData   (arbReq),
    .inValid  (arbReqValid),
    .inReady  (arbReqReady),
    .outData  (bufReq),
    .outValid (bufReqValid),
    .outReady (bufReqReady)
  );

  // Control token buffer
  elasticFifo #(
    .payload_t (ctrlToken_t),
    .DEPTH     (CTRL_FIFO_DEPTH)
  ) ctrlFifo0 (
    .clk      (clk),
    .rst      (rst),
    .inData   (ctrl),
    .inValid  (ctrlValid),
    .inReady  (ctrlReady),
    .outData  (bufCtrl),
    .outValid (bufCtrlValid),
    .outReady (bufCtrlReady)
  );

  memControllerLoadless memCtrl0 (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (bufCtrl),
    .ctrlValid     (bufCtrlValid),
    .ctrlReady     (bufCtrlReady),
    .storeReq      (bufReq),
    .storeReqValid (bufReqValid),
    .storeReqReady (bufReqReady),
    .memDoneValid  (memDoneValid),
    .memDoneReady  (memDoneReady),
    .storeEn       (storeEn),
    .storeAddr     (storeAddr),
    .storeData     (storeData)
  );

  dualPortRam ram0 (
    .clk       (clk),
    .storeEn   (storeEn),
    .storeAddr (storeAddr),
    .storeData (storeData),
    .rdEn      (rdEn),
    .rdAddr    (rdAddr),
    .rdData    (rdData)
  );

endmodule

// File: storeCtrl.f
logic/storePkg.sv
logic/elasticFifo.sv
logic/storeArbiter.sv
logic/memControllerLoadless.sv
logic/dualPortRam.sv
logic/storeSubsystem.sv
testbench/storeSubsystemTb.sv

// File: testbench/storeSubsystemTb.sv
`timescale 1ns/100ps

module storeSubsystemTb import storePkg::*; ();

  localparam int NUM_ROWS = 4;
  localparam int NUM_ST = 13;
  localparam int RESET_CYCLES = 5;
  localparam int CYCLE_LIMIT = 10 * NUM_ST + 50 * NUM_ROWS + RESET_CYCLES;

  // Row r owns the stores from rowStart[r] onwards
  int rowStart [NUM_ROWS] = '{0, 2, 7, 9};
  int rowLen [NUM_ROWS] = '{2, 5, 2, 4};
  int rowCount [NUM_ROWS] = '{2, 5, 2, 4};
  bit rowCtrlFirst [NUM_ROWS] = '{0, 1, 1, 0};
  bit rowDelay [NUM_ROWS] = '{0, 1, 0, 1};
  // Per store the port, address, LFSR or fixed data and the cycles its data lags
  int sPort [NUM_ST] = '{0, 1, 0, 0, 0, 1, 1, 1, 1, 0, 1, 0, 1};
  logic [ADDR_WIDTH-1:0] sAddr [NUM_ST] = '{8'h10, 8'h10, 8'h20, 8'h21, 8'h22, 8'h30, 8'h31,
    8'h40, 8'h41, 8'h50, 8'h21, 8'h21, 8'h51};
  bit sRand [NUM_ST] = '{1, 1, 1, 1, 0, 1, 0, 1, 1, 0, 1, 1, 0};
  logic [DATA_WIDTH-1:0] sFixed [NUM_ST] = '{0, 0, 0, 0, 32'h1234_5678, 0, 32'h0bad_f00d,
    0, 0, 32'hcafe_0001, 0, 0, 32'h5a5a_a5a5};
  int sLag [NUM_ST] = '{0, 0, 0, 0, 0, 0, 0, 4, 0, 0, 0, 0, 0};

  logic clk;
  logic rst;
  logic [NUM_STORE-1:0][ADDR_WIDTH-1:0] stAddr;
  logic [NUM_STORE-1:0][DATA_WIDTH-1:0] stData;
  logic [NUM_STORE-1:0] stAddrValid;
  logic [NUM_STORE-1:0] stDataValid;
  logic [NUM_STORE-1:0] stAddrReady;
  logic [NUM_STORE-1:0] stDataReady;
  ctrlToken_t ctrl;
  logic ctrlValid;
  logic ctrlReady;
  logic memDoneValid;
  logic memDoneReady;
  logic rdEn;
  logic [ADDR_WIDTH-1:0] rdAddr;
  logic [DATA_WIDTH-1:0] rdData;

  logic [DATA_WIDTH-1:0] modelMem [2 ** ADDR_WIDTH];
  logic [DATA_WIDTH-1:0] dataVal [NUM_ST];
  logic [15:0] lfsr;
  int lastServed = NUM_STORE - 1;
  int accepted;
  bit tokenSent;
  int errCount = 0;
  int checkCount = 0;
  int cycles = 0;

  storeSubsystem dut0 (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int nextOf(input int p, input int from, input int stop);
    int i;
    i = from;
    while (i < stop && sPort[i] != p) begin
      i++;
    end
    return i;
  endfunction

  // Pick data, then replay the round-robin order to get the final word per address
  task automatic predictRow(input int r);
    int pos [NUM_STORE];
    int stop;
    int pick;
    int p;
    stop = rowStart[r] + rowLen[r];
    for (int i = rowStart[r]; i < stop; i++) begin
      dataVal[i] = sRand[i] ? randBits(DATA_WIDTH) : sFixed[i];
    end
    for (int q = 0; q < NUM_STORE; q++) begin
      pos[q] = nextOf(q, rowStart[r], stop);
    end
    for (int n = 0; n < rowLen[r]; n++) begin
      pick = -1;
      for (int k = 1; k <= NUM_STORE; k++) begin
        p = (lastServed + k) % NUM_STORE;
        if (pick < 0 && pos[p] < stop) begin
          pick = p;
        end
      end
      modelMem[sAddr[pos[pick]]] = dataVal[pos[pick]];
      lastServed = pick;
      pos[pick] = nextOf(pick, pos[pick] + 1, stop);
    end
  endtask

  task automatic drivePort(input int p, input int r);
    if (rowCtrlFirst[r]) begin
      while (!tokenSent) @(negedge clk);
    end
    @(posedge clk);
    for (int i = rowStart[r]; i < rowStart[r] + rowLen[r]; i++) begin
      if (sPort[i] == p) begin
        stAddr[p] <= sAddr[i];
        stAddrValid[p] <= 1'b1;
        if (sLag[i] > 0) begin
          stDataValid[p] <= 1'b0;
          repeat (sLag[i]) begin
            @(posedge clk);
            checkCount++;
            assert (!stAddrReady[p] && !stDataReady[p]) else begin
              errCount++;
              $display("port %0d got ready while its data was missing", p);
            end
          end
        end
        stData[p] <= dataVal[i];
        stDataValid[p] <= 1'b1;
        do @(posedge clk); while (!(stAddrReady[p] && stDataReady[p]));
        accepted++;
      end
    end
    stAddrValid[p] <= 1'b0;
    stDataValid[p] <= 1'b0;
  endtask

  task automatic sendCtrl(input int r);
    if (!rowCtrlFirst[r]) begin
      while (accepted < rowLen[r]) @(negedge clk);
    end
    @(posedge clk);
    ctrl.storeCount <= COUNT_WIDTH'(rowCount[r]);
    ctrlValid <= 1'b1;
    do @(posedge clk); while (!ctrlReady);
    ctrlValid <= 1'b0;
    tokenSent = 1'b1;
  endtask

  task automatic watchDone(input int r);
    int delay;
    do @(negedge clk); while (!memDoneValid);
    checkCount++;
    assert (tokenSent && accepted >= rowCount[r]) else begin
      errCount++;
      $display("memDoneValid rose early: token sent %0d, %0d of %0d stores accepted",
        tokenSent, accepted, rowCount[r]);
    end
    delay = rowDelay[r] ? int'(randBits(3)) : 0;
    repeat (delay + 1) begin
      @(negedge clk);
      checkCount++;
      assert (memDoneValid) else begin
        errCount++;
        $display("MISMATCH memDoneValid: got %0h expected 1", memDoneValid);
      end
      @(posedge clk);
    end
    memDoneReady <= 1'b1;
    @(posedge clk);
    memDoneReady <= 1'b0;
    // Exactly one token per batch
    repeat (3) begin
      @(negedge clk);
      checkCount++;
      assert (!memDoneValid) else begin
        errCount++;
        $display("MISMATCH memDoneValid: got %0h expected 0", memDoneValid);
      end
    end
  endtask

  task automatic readBack(input int r);
    for (int i = rowStart[r]; i < rowStart[r] + rowLen[r]; i++) begin
      @(posedge clk);
      rdEn <= 1'b1;
      rdAddr <= sAddr[i];
      @(posedge clk);
      rdEn <= 1'b0;
      @(negedge clk);
      checkCount++;
      assert (rdData === modelMem[sAddr[i]]) else begin
        errCount++;
        $display("MISMATCH rdData at %02h: got %08h expected %08h", sAddr[i], rdData,
          modelMem[sAddr[i]]);
      end
    end
  endtask

  initial begin
    int errBefore;
    clk = 1'b0;
    rst = 1'b1;
    stAddr = '0;
    stData = '0;
    stAddrValid = '0;
    stDataValid = '0;
    ctrl = '0;
    ctrlValid = 1'b0;
    memDoneReady = 1'b0;
    rdEn = 1'b0;
    rdAddr = '0;
    lfsr = 16'd33;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkCount += 2;
    assert (ctrlReady) else begin
      errCount++;
      $display("ctrlReady still low two cycles after reset");
    end
    assert (!memDoneValid) else begin
      errCount++;
      $display("MISMATCH memDoneValid: got %0h expected 0", memDoneValid);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      errBefore = errCount;
      predictRow(r);
      accepted = 0;
      tokenSent = 1'b0;
      fork
        sendCtrl(r);
        drivePort(0, r);
        drivePort(1, r);
        watchDone(r);
      join
      readBack(r);
      $display("row %0d: %0d stores, %0d errors", r, rowLen[r], errCount - errBefore);
    end
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
